// File: verification/pet_bus_golden.txt
# kind rw_n addr data, then expected ram_ce_no pia1 pia2 via io_oe_no ram_we_no ram_addr doe dout
# pi rows: dout is bus_data_o on writes and pi_data_o after pi_done_o on reads
# decode, CPU reads in every region
cpu 1 0400 00 0 1 1 1 1 1 1 0 00
cpu 1 7fff 00 0 1 1 1 1 1 3 0 00
cpu 1 9000 00 0 1 1 1 1 1 0 0 00
cpu 1 f000 00 0 1 1 1 1 1 0 0 00
cpu 1 e800 00 1 1 1 1 0 1 2 0 00
cpu 1 e810 00 1 0 1 1 0 1 2 0 00
cpu 1 e821 00 1 1 0 1 0 1 2 0 00
cpu 1 e84f 00 1 1 1 0 0 1 2 0 00
cpu 1 e880 00 1 1 1 1 0 1 2 0 00
# ROM protection
cpu 0 0400 11 0 1 1 1 1 0 1 0 00
cpu 0 c000 22 0 1 1 1 1 1 0 0 00
cpu 1 c000 00 0 1 1 1 1 1 0 0 00
# VRAM mirroring on the CPU side and the Pi side
cpu 1 8c00 00 0 1 1 1 1 1 0 0 00
cpu 1 4c00 00 0 1 1 1 1 1 3 0 00
pi 0 8c00 41 0 1 1 1 1 0 3 1 41
pi 1 8c00 5a 0 1 1 1 1 1 3 0 5a
# Pi write and read of main RAM
pi 0 0400 a5 0 1 1 1 1 0 1 1 a5
pi 1 0400 3c 0 1 1 1 1 1 1 0 3c
pi 1 1c00 c3 0 1 1 1 1 1 3 0 c3
# keyboard, row 0 untouched since reset
cpu 1 e812 00 1 1 1 1 1 1 2 1 ff
pi 0 e803 f7 0 1 1 1 1 0 2 1 f7
cpu 0 e810 03 1 0 1 1 0 1 2 0 00
cpu 1 e812 00 1 1 1 1 1 1 2 1 f7
cpu 0 e810 0c 1 0 1 1 0 1 2 0 00
cpu 1 e812 00 1 1 1 1 1 1 2 1 ff

// File: pet_bus.f
source/pet_bus_pkg.sv
source/bus_timing.sv
source/address_decoder.sv
source/keyboard_intercept.sv
source/bus_combiner.sv
source/pet_bus.sv
verification/pet_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pet_bus_tb
FILELIST  ?= pet_bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A simulator that stops early counts as a failure
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "sim failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/pet_bus_tb.sv
// Testbench for the PET bus core that replays the golden vector file against the DUT
`timescale 1ns/10ps

module pet_bus_tb;
    localparam int WAIT_LIMIT = 40;               // Cycles per wait before giving up

    logic         clk_16_i;
    logic         rst_i;
    logic [15:0]  cpu_addr_i;
    logic         cpu_rw_n_i;
    logic [7:0]   bus_data_i;
    logic [15:0]  pi_addr_i;
    logic [7:0]   pi_data_i;
    logic         pi_rw_n_i;
    logic         pi_valid_i;
    logic         pi_done_o, clk_cpu_o, cpu_en_no;
    logic [7:0]   pi_data_o, bus_data_o;
    logic [15:0]  bus_addr_o;
    logic         bus_addr_oe_o, bus_data_oe_o, bus_rw_n_o;
    logic [11:10] ram_addr_o;
    logic         ram_ce_no, ram_oe_no, ram_we_no;
    logic         pia1_cs2_no, pia2_cs2_no, via_cs2_no, io_oe_no;

    int           fd;                             // Golden file handle
    int           got_n;
    int           vec_no;                         // Vector being run
    int           checks;
    int           errors;
    int           timeouts;
    string        kind;                           // cpu or pi
    string        rest;                           // Rest of a comment line
    logic         rw_n;
    logic [15:0]  addr;
    logic [7:0]   data;
    logic         ce_x, pia1_x, pia2_x, via_x, io_x, we_x, doe_x; // Expected levels
    logic [1:0]   ra_x;                           // Expected RAM A11/A10
    logic [7:0]   dout_x;                         // Expected data byte

    pet_bus pet_bus_i (.*);

    always #2 clk_16_i = ~clk_16_i;               // 4 ns period

    task automatic check_field(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s is %h, expected %h in vector %0d",
                     $time, what, got, exp, vec_no);
        end
    endtask

    // Selects and RAM controls common to both vector kinds
    task automatic check_selects();
        check_field("ram_ce_no", 16'(ram_ce_no), 16'(ce_x));
        check_field("ram_oe_no", 16'(ram_oe_no), 16'(ce_x || !rw_n)); // RAM drives only reads
        check_field("pia1_cs2_no", 16'(pia1_cs2_no), 16'(pia1_x));
        check_field("pia2_cs2_no", 16'(pia2_cs2_no), 16'(pia2_x));
        check_field("via_cs2_no", 16'(via_cs2_no), 16'(via_x));
        check_field("io_oe_no", 16'(io_oe_no), 16'(io_x));
        check_field("ram_we_no", 16'(ram_we_no), 16'(we_x));
        check_field("ram_addr_o", 16'(ram_addr_o), 16'(ra_x));
    endtask

    task automatic run_cpu_line();
        int n;
        @(posedge clk_16_i);
        cpu_addr_i <= addr;
        cpu_rw_n_i <= rw_n;
        bus_data_i <= data;                       // CPU write data or row select
        pi_valid_i <= 1'b0;
        pi_rw_n_i  <= 1'b1;
        @(negedge clk_16_i);
        for (n = 0; !cpu_en_no && n < WAIT_LIMIT; n++)
            @(negedge clk_16_i);                  // Let a running CPU slot finish
        if (!cpu_en_no) begin
            $display("timeout: CPU slot never ended in vector %0d", vec_no);
            timeouts++;
            return;
        end
        for (n = 0; cpu_en_no && n < WAIT_LIMIT; n++)
            @(negedge clk_16_i);
        if (cpu_en_no) begin
            $display("timeout: cpu_en_no never went low in vector %0d", vec_no);
            timeouts++;
            return;
        end
        check_selects();                          // Mid cycle of the first CPU count
        check_field("clk_cpu_o", 16'(clk_cpu_o), 16'd1);
        check_field("bus_data_oe_o", 16'(bus_data_oe_o), 16'(doe_x));
        if (doe_x)
            check_field("bus_data_o", 16'(bus_data_o), 16'(dout_x));
    endtask

    task automatic run_pi_line();
        int n;
        int strobes;
        strobes = 0;
        @(posedge clk_16_i);
        pi_addr_i  <= addr;
        pi_data_i  <= rw_n ? ~data : data;        // Golden byte only on a write
        pi_rw_n_i  <= rw_n;
        pi_valid_i <= 1'b1;
        bus_data_i <= rw_n ? data : ~data;        // Byte the RAM returns on a read
        cpu_rw_n_i <= 1'b1;
        @(negedge clk_16_i);
        for (n = 0; !pi_done_o && n < WAIT_LIMIT; n++) begin
            if (bus_addr_oe_o) begin              // Strobe counts
                strobes++;
                check_selects();
                check_field("clk_cpu_o", 16'(clk_cpu_o), 16'd0);
                check_field("bus_addr_o", bus_addr_o, addr);
                check_field("bus_rw_n_o", 16'(bus_rw_n_o), 16'(rw_n));
                check_field("bus_data_oe_o", 16'(bus_data_oe_o), 16'(doe_x));
                if (doe_x)
                    check_field("bus_data_o", 16'(bus_data_o), 16'(dout_x));
            end
            @(negedge clk_16_i);
        end
        if (!pi_done_o) begin
            $display("timeout: pi_done_o never pulsed in vector %0d", vec_no);
            timeouts++;
            return;
        end
        check_field("strobe cycles", 16'(strobes), 16'd4); // Counts 2 to 5
        if (rw_n)
            check_field("pi_data_o", 16'(pi_data_o), 16'(dout_x));
    endtask

    // Idle bus after reset with clk_cpu, done and both enables low and active-low lines high
    task automatic check_reset_state();
        check_field("reset outputs", 16'({clk_cpu_o, pi_done_o, bus_addr_oe_o,
                    bus_data_oe_o, cpu_en_no, ram_ce_no, ram_oe_no, ram_we_no,
                    pia1_cs2_no, pia2_cs2_no, via_cs2_no, io_oe_no}), 16'h00FF);
    endtask

    initial begin
        clk_16_i   = 1'b0;
        rst_i      = 1'b1;
        cpu_addr_i = '0;
        cpu_rw_n_i = 1'b1;
        bus_data_i = '0;
        pi_addr_i  = '0;
        pi_data_i  = '0;
        pi_rw_n_i  = 1'b1;
        pi_valid_i = 1'b0;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        vec_no     = 0;
        repeat (4) @(posedge clk_16_i);
        rst_i <= 1'b0;
        @(negedge clk_16_i);
        check_reset_state();
        fd = $fopen("verification/pet_bus_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/pet_bus_golden.txt");
            errors++;
        end else begin
            while (timeouts == 0 && $fscanf(fd, "%s", kind) == 1) begin
                if (kind.substr(0, 0) == "#") begin
                    got_n = $fgets(rest, fd);     // Skip the comment
                end else begin
                    got_n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", rw_n, addr,
                                    data, ce_x, pia1_x, pia2_x, via_x, io_x, we_x, ra_x,
                                    doe_x, dout_x);
                    vec_no++;
                    if (got_n != 12) begin
                        $display("golden vector %0d has missing columns", vec_no);
                        errors++;
                    end else if (kind == "cpu") begin
                        run_cpu_line();
                    end else if (kind == "pi") begin
                        run_pi_line();
                    end else begin
                        $display("golden vector %0d has unknown kind %s", vec_no, kind);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        $display("vectors %0d, checks %0d, errors %0d, timeouts %0d",
                 vec_no, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && vec_no > 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: source/pet_bus.sv
// PET bus-control core top level joining the slot timer, decoder, keyboard intercept and combiner
`timescale 1ns/10ps

module pet_bus import pet_bus_pkg::*; (
    input  logic         clk_16_i,                // 16 MHz system clock
    input  logic         rst_i,                   // Sync reset, active high
    input  logic [15:0]  cpu_addr_i,
    input  logic         cpu_rw_n_i,
    input  logic [7:0]   bus_data_i,
    input  logic [15:0]  pi_addr_i,
    input  logic [7:0]   pi_data_i,
    input  logic         pi_rw_n_i,
    input  logic         pi_valid_i,
    output logic         pi_done_o,
    output logic [7:0]   pi_data_o,
    output logic         clk_cpu_o,
    output logic         cpu_en_no,
    output logic [15:0]  bus_addr_o,
    output logic         bus_addr_oe_o,
    output logic [7:0]   bus_data_o,
    output logic         bus_data_oe_o,
    output logic         bus_rw_n_o,
    output logic [11:10] ram_addr_o,
    output logic         ram_ce_no,
    output logic         ram_oe_no,
    output logic         ram_we_no,
    output logic         pia1_cs2_no,
    output logic         pia2_cs2_no,
    output logic         via_cs2_no,
    output logic         io_oe_no
);
    bus_slot_e  slot;
    logic       pi_read, pi_write;                // Pi RAM strobes
    logic       ram_sel, io_sel, pia1_sel, pia2_sel, via_sel;
    logic       readonly, mirrored;
    logic       kbd_active;
    logic [7:0] kbd_data;

    bus_timing bus_timing_i (
        .clk_16_i(clk_16_i), .rst_i(rst_i), .pi_valid_i(pi_valid_i), .pi_rw_n_i(pi_rw_n_i),
        .slot_o(slot), .clk_cpu_o(clk_cpu_o), .cpu_en_no(cpu_en_no),
        .pi_read_o(pi_read), .pi_write_o(pi_write), .pi_done_o(pi_done_o)
    );

    address_decoder address_decoder_i (
        .cpu_addr_i(cpu_addr_i), .ram_sel_o(ram_sel), .io_sel_o(io_sel),
        .pia1_sel_o(pia1_sel), .pia2_sel_o(pia2_sel), .via_sel_o(via_sel),
        .readonly_o(readonly), .mirrored_o(mirrored)
    );

    keyboard_intercept keyboard_intercept_i (
        .clk_16_i(clk_16_i), .rst_i(rst_i), .cpu_addr_i(cpu_addr_i), .cpu_rw_n_i(cpu_rw_n_i),
        .cpu_en_no(cpu_en_no), .bus_data_i(bus_data_i), .pi_addr_i(pi_addr_i),
        .pi_data_i(pi_data_i), .pi_write_i(pi_write),
        .kbd_active_o(kbd_active), .kbd_data_o(kbd_data)
    );

    bus_combiner bus_combiner_i (
        .clk_16_i(clk_16_i), .rst_i(rst_i), .slot_i(slot), .cpu_en_no(cpu_en_no),
        .cpu_rw_n_i(cpu_rw_n_i), .cpu_addr_i(cpu_addr_i), .pi_addr_i(pi_addr_i),
        .pi_data_i(pi_data_i), .bus_data_i(bus_data_i), .pi_read_i(pi_read),
        .pi_write_i(pi_write), .ram_sel_i(ram_sel), .io_sel_i(io_sel),
        .pia1_sel_i(pia1_sel), .pia2_sel_i(pia2_sel), .via_sel_i(via_sel),
        .readonly_i(readonly), .mirrored_i(mirrored), .kbd_active_i(kbd_active),
        .kbd_data_i(kbd_data), .pi_data_o(pi_data_o), .bus_addr_o(bus_addr_o),
        .bus_addr_oe_o(bus_addr_oe_o), .bus_data_o(bus_data_o),
        .bus_data_oe_o(bus_data_oe_o), .bus_rw_n_o(bus_rw_n_o), .ram_addr_o(ram_addr_o),
        .ram_ce_no(ram_ce_no), .ram_oe_no(ram_oe_no), .ram_we_no(ram_we_no),
        .pia1_cs2_no(pia1_cs2_no), .pia2_cs2_no(pia2_cs2_no), .via_cs2_no(via_cs2_no),
        .io_oe_no(io_oe_no)
    );

endmodule

// File: source/bus_combiner.sv
// Bus combiner that merges timing, decode and keyboard results into the bus and RAM controls
`timescale 1ns/10ps

module bus_combiner import pet_bus_pkg::*; (
    input  logic        clk_16_i,                 // 16 MHz system clock
    input  logic        rst_i,                    // Sync reset, active high
    input  bus_slot_e   slot_i,                   // Current bus owner
    input  logic        cpu_en_no,                // 0 = CPU drives the bus
    input  logic        cpu_rw_n_i,               // 1 = CPU read
    input  logic [15:0] cpu_addr_i,               // 6502 address
    input  logic [15:0] pi_addr_i,                // Pi request address
    input  logic [7:0]  pi_data_i,                // Pi write data
    input  logic [7:0]  bus_data_i,               // Data bus as seen by the FPGA
    input  logic        pi_read_i,                // Pi read strobe
    input  logic        pi_write_i,               // Pi write strobe
    input  logic        ram_sel_i,
    input  logic        io_sel_i,
    input  logic        pia1_sel_i,
    input  logic        pia2_sel_i,
    input  logic        via_sel_i,
    input  logic        readonly_i,               // ROM area
    input  logic        mirrored_i,               // VRAM window
    input  logic        kbd_active_i,             // Port B read intercepted
    input  logic [7:0]  kbd_data_i,               // Key row for the CPU
    output logic [7:0]  pi_data_o,                // Last byte read for the Pi
    output logic [15:0] bus_addr_o,
    output logic        bus_addr_oe_o,            // 1 = FPGA drives the address bus
    output logic [7:0]  bus_data_o,
    output logic        bus_data_oe_o,            // 1 = FPGA drives the data bus
    output logic        bus_rw_n_o,
    output logic [11:10] ram_addr_o,              // RAM A11/A10, used for VRAM mirroring
    output logic        ram_ce_no,
    output logic        ram_oe_no,
    output logic        ram_we_no,
    output logic        pia1_cs2_no,
    output logic        pia2_cs2_no,
    output logic        via_cs2_no,
    output logic        io_oe_no                  // I/O data transceiver enable
);
    logic cpu_act;                                // CPU slot with CPU on the bus
    logic pi_slot;
    logic pi_access;                              // Either Pi strobe up
    logic kbd_hit;                                // Intercept owns this CPU read

    assign pi_slot   = (slot_i == SLOT_PI);
    assign cpu_act   = (slot_i == SLOT_CPU) && !cpu_en_no;
    assign pi_access = pi_read_i || pi_write_i;
    assign kbd_hit   = cpu_act && kbd_active_i;

    // Peripherals follow decode, PIA1 and the transceiver step aside for the intercept
    assign pia1_cs2_no = !(cpu_act && pia1_sel_i && !kbd_active_i);
    assign pia2_cs2_no = !(cpu_act && pia2_sel_i);
    assign via_cs2_no  = !(cpu_act && via_sel_i);
    assign io_oe_no    = !(cpu_act && io_sel_i && !kbd_active_i);

    assign ram_ce_no = !(pi_access || (cpu_act && ram_sel_i));
    assign ram_oe_no = !(pi_read_i || (cpu_act && ram_sel_i && cpu_rw_n_i));
    assign ram_we_no = !(pi_write_i || (cpu_act && ram_sel_i && !cpu_rw_n_i && !readonly_i));

    // Pi address goes out only while a strobe is up
    assign bus_addr_oe_o = pi_access;
    assign bus_addr_o    = pi_access ? pi_addr_i : '0;
    assign bus_rw_n_o    = !pi_write_i;

    assign bus_data_oe_o = pi_write_i || kbd_hit;
    assign bus_data_o    = pi_write_i ? pi_data_i :
                           kbd_hit    ? kbd_data_i : 8'h00;

    // Pi sees all of RAM, the CPU sees the screen repeated across $8000-$8FFF
    assign ram_addr_o = pi_slot    ? pi_addr_i[11:10] :
                        mirrored_i ? 2'b00 : cpu_addr_i[11:10];

    // Last strobe count leaves the count-5 byte in place
    always_ff @(posedge clk_16_i) begin
        if (rst_i)
            pi_data_o <= '0;
        else if (pi_read_i)
            pi_data_o <= bus_data_i;
    end

    // RAM must never see output enable and write enable together
    assert property (@(posedge clk_16_i) disable iff (rst_i) !(!ram_oe_no && !ram_we_no))
        else $error("bus_combiner: ram_oe_no and ram_we_no both low");

endmodule

// File: source/keyboard_intercept.sv
// Keyboard intercept that answers PIA1 port B reads from a Pi-written key matrix
`timescale 1ns/10ps

module keyboard_intercept import pet_bus_pkg::*; (
    input  logic        clk_16_i,                 // 16 MHz system clock
    input  logic        rst_i,                    // Sync reset, active high
    input  logic [15:0] cpu_addr_i,               // 6502 address
    input  logic        cpu_rw_n_i,               // 1 = CPU read
    input  logic        cpu_en_no,                // 0 = CPU slot
    input  logic [7:0]  bus_data_i,               // Data bus as seen by the FPGA
    input  logic [15:0] pi_addr_i,                // Pi request address
    input  logic [7:0]  pi_data_i,                // Pi write data
    input  logic        pi_write_i,               // Pi write strobe
    output logic        kbd_active_o,             // CPU is reading port B
    output logic [7:0]  kbd_data_o                // Row data returned to the CPU
);
    logic [7:0] key_rows [KBD_ROWS];              // Active-low key state per row
    logic [3:0] sel_row;                          // Row picked through port A
    logic       pi_row_wr;                        // Pi write hits the matrix
    logic       cpu_row_wr;                       // CPU write to port A

    assign pi_row_wr  = pi_write_i &&
                        (pi_addr_i >= KBD_PI_BASE) &&
                        (pi_addr_i < KBD_PI_BASE + 16'(KBD_ROWS));
    assign cpu_row_wr = !cpu_en_no && !cpu_rw_n_i && (cpu_addr_i == KBD_PORT_A);

    // Matrix starts with no keys down
    always_ff @(posedge clk_16_i) begin
        if (rst_i) begin
            for (int r = 0; r < KBD_ROWS; r++)
                key_rows[r] <= 8'hFF;
        end else if (pi_row_wr) begin
            key_rows[pi_addr_i[3:0]] <= pi_data_i; // Offset from $E800 is the row
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (rst_i)
            sel_row <= '0;
        else if (cpu_row_wr)
            sel_row <= bus_data_i[3:0];            // Low nibble picks the row
    end

    assign kbd_active_o = cpu_rw_n_i && (cpu_addr_i == KBD_PORT_B);

    // Rows past the matrix read as no keys pressed
    always_comb begin
        if (sel_row < 4'(KBD_ROWS))
            kbd_data_o = key_rows[sel_row];
        else
            kbd_data_o = 8'hFF;
    end

    // Selected row must stay a known value inside the 4-bit range
    assert property (@(posedge clk_16_i) disable iff (rst_i)
        !$isunknown(sel_row) && (int'(sel_row) < 16))
        else $error("keyboard_intercept: row select out of range");

endmodule

// File: source/address_decoder.sv
// PET address decoder producing region selects and readonly and mirrored flags
`timescale 1ns/10ps

module address_decoder import pet_bus_pkg::*; (
    input  logic [15:0] cpu_addr_i,               // 6502 address
    output logic        ram_sel_o,                // RAM, VRAM or ROM area
    output logic        io_sel_o,                 // Anywhere in $E8xx
    output logic        pia1_sel_o,               // $E810-$E813
    output logic        pia2_sel_o,               // $E820-$E823
    output logic        via_sel_o,                // $E840-$E84F
    output logic        readonly_o,               // ROM area, CPU writes blocked
    output logic        mirrored_o                // VRAM window, A11/A10 forced low
);
    logic in_ram;                                 // $0000-$7FFF
    logic in_vram;                                // $8000-$8FFF
    logic in_io;                                  // $E800-$E8FF
    logic in_rom;                                 // $9000 up, minus I/O page

    always_comb begin
        in_ram  = (cpu_addr_i <= RAM_TOP);
        in_vram = (cpu_addr_i >= VRAM_BASE) && (cpu_addr_i <= VRAM_TOP);
        in_io   = (cpu_addr_i >= IO_BASE) && (cpu_addr_i <= IO_TOP);
        in_rom  = (cpu_addr_i >= ROM_BASE) && !in_io;
    end

    // ROM images live in RAM on the clone, so ROM space also selects RAM
    assign ram_sel_o  = in_ram || in_vram || in_rom;
    assign readonly_o = in_rom;
    assign mirrored_o = in_vram;                  // 1KB/2KB screen repeats over 4KB

    // Peripheral selects decode only the upper address bits
    assign io_sel_o   = in_io;
    assign pia1_sel_o = (cpu_addr_i[15:2] == PIA1_BASE[15:2]);
    assign pia2_sel_o = (cpu_addr_i[15:2] == PIA2_BASE[15:2]);
    assign via_sel_o  = (cpu_addr_i[15:4] == VIA_BASE[15:4]);

endmodule

// File: source/bus_timing.sv
// Bus slot timer that splits each 1 MHz cycle into a Pi slot and a CPU slot
`timescale 1ns/10ps

module bus_timing import pet_bus_pkg::*; (
    input  logic      clk_16_i,                   // 16 MHz system clock
    input  logic      rst_i,                      // Sync reset, active high
    input  logic      pi_valid_i,                 // Pi request pending (level)
    input  logic      pi_rw_n_i,                  // 1 = Pi read, 0 = Pi write
    output bus_slot_e slot_o,                     // Current bus owner
    output logic      clk_cpu_o,                  // 1 MHz CPU clock
    output logic      cpu_en_no,                  // 0 = CPU drives the bus
    output logic      pi_read_o,                  // RAM read strobe for the Pi
    output logic      pi_write_o,                 // RAM write strobe for the Pi
    output logic      pi_done_o                   // One-cycle pulse, request served
);
    logic [SLOT_CNT_W-1:0] cnt;                   // Position inside the bus cycle
    logic                  pi_pending;            // Request captured at count 0
    logic                  pi_rw_n;               // Direction of captured request
    logic                  strobe_win;            // Counts 2-5

    always_ff @(posedge clk_16_i) begin
        if (rst_i) begin
            cnt        <= '0;
            pi_pending <= 1'b0;
        end else begin
            if (cnt == SLOT_CNT_W'(SLOT_CYCLES - 1))
                cnt <= '0;                        // Wrap at end of bus cycle
            else
                cnt <= cnt + 1'b1;
            if (cnt == '0)
                pi_pending <= pi_valid_i;         // Late requests wait a full cycle
        end
    end

    // Direction is payload, sampled together with the request
    always_ff @(posedge clk_16_i) begin
        if (cnt == '0)
            pi_rw_n <= pi_rw_n_i;
    end

    assign slot_o     = (cnt < SLOT_CNT_W'(PI_SLOT_LEN)) ? SLOT_PI : SLOT_CPU;
    assign clk_cpu_o  = (slot_o == SLOT_CPU);     // High for counts 8-15
    assign cpu_en_no  = (slot_o != SLOT_CPU);
    assign strobe_win = (cnt >= SLOT_CNT_W'(PI_STROBE_FIRST)) &&
                        (cnt <= SLOT_CNT_W'(PI_STROBE_LAST));
    assign pi_read_o  = pi_pending && strobe_win && pi_rw_n;
    assign pi_write_o = pi_pending && strobe_win && !pi_rw_n;
    assign pi_done_o  = pi_pending && (cnt == SLOT_CNT_W'(PI_SLOT_LEN - 1)); // Count 7

    // Read and write strobes are mutually exclusive
    assert property (@(posedge clk_16_i) disable iff (rst_i) !(pi_read_o && pi_write_o))
        else $error("bus_timing: pi_read and pi_write both high");

endmodule

// File: source/pet_bus_pkg.sv
// PET bus-control package with the memory map, bus phase and keyboard constants
package pet_bus_pkg;

    // Owner of the shared bus in the current half of a 1 MHz cycle
    typedef enum logic {
        SLOT_PI  = 1'b0,                          // Raspberry Pi request slot
        SLOT_CPU = 1'b1                           // 6502 slot
    } bus_slot_e;

    localparam int SLOT_CYCLES     = 16;          // 16 MHz ticks per bus cycle
    localparam int SLOT_CNT_W      = $clog2(SLOT_CYCLES);
    localparam int PI_SLOT_LEN     = 8;           // Counts 0-7 go to the Pi
    localparam int PI_STROBE_FIRST = 2;           // First count with a Pi strobe
    localparam int PI_STROBE_LAST  = 5;           // Last count with a Pi strobe

    // PET memory map
    localparam logic [15:0] RAM_TOP   = 16'h7FFF; // End of main RAM
    localparam logic [15:0] VRAM_BASE = 16'h8000; // Video RAM window
    localparam logic [15:0] VRAM_TOP  = 16'h8FFF;
    localparam logic [15:0] ROM_BASE  = 16'h9000; // ROM images held in RAM
    localparam logic [15:0] IO_BASE   = 16'hE800; // I/O page
    localparam logic [15:0] IO_TOP    = 16'hE8FF;
    localparam logic [15:0] PIA1_BASE = 16'hE810; // 4 registers
    localparam logic [15:0] PIA2_BASE = 16'hE820; // 4 registers
    localparam logic [15:0] VIA_BASE  = 16'hE840; // 16 registers

    // Keyboard scan ports on PIA1
    localparam logic [15:0] KBD_PORT_A  = 16'hE810; // Row select, CPU writes
    localparam logic [15:0] KBD_PORT_B  = 16'hE812; // Column data, CPU reads
    localparam logic [15:0] KBD_PI_BASE = 16'hE800; // Pi writes row r here plus r
    localparam int          KBD_ROWS    = 10;

endpackage
